// ==== tb/perfCases.txt ====
# mode (1 one-shot, 0 continuous), window length, burst offset, burst length, density (hex)
# density bits from msb: loadMiss[1:0] storeMiss icMiss branchPredMiss memDepPredMiss
#   stallByScheduler stallByActiveList inRecovery
1 40 2 30 1ff
1 64 5 50 0aa
1 100 10 80 155
1 16 2 10 1ff
1 200 50 100 180
1 8 2 2 1ff
0 8 0 4 1ff
0 1 0 2 0ff
0 0 0 2 1ff
1 300 3 100 07f
1 50 20 20 001
1 128 2 100 100
0 12 2 6 155
1 33 4 25 1fe
1 20 2 14 000
0 5 1 3 1ff
1 150 60 80 1c3
1 75 2 60 038
0 20 3 10 0aa
1 12 2 6 1ff

// ==== sources.f ====
+incdir+src
src/PerfEventTypes.sv
src/PerfBusTypes.sv
src/PerfCounterBank.sv
src/WindowTimer.sv
src/PerfControlFsm.sv
src/PerfSnapshot.sv
src/PerfRegisterPort.sv
src/PerfMonitorTop.sv
tb/PerfMonitor_assertions.sv
tb/PerfMonitorTb.sv

// ==== Makefile ====
SIM       := verilator
TOP       := PerfMonitorTb
FILELIST  := sources.f
SIMFLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR := obj_dir
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS   := src/perfMonitor_config.svh
BINARY    := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BINARY): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/PerfMonitorTb.sv ====
/* Runs every case of tb/perfCases.txt against PerfMonitorTop, so it must be started from the
   project root. Snapshots are compared with a per-class sum of the driven event bits. */
`timescale 1ns/1ps
`include "perfMonitor_config.svh"

module PerfMonitorTb;
    import PerfEventTypes::*;
    import PerfBusTypes::*;

    localparam int EVENT_WIDTH = $bits(PerfEvent);
    // Back-to-back windows that a continuous case must complete before it is stopped.
    localparam int CONT_WINDOWS = 4;

    typedef struct packed {
        logic oneShot;
        logic [15:0] window;
        logic [15:0] offset;
        logic [15:0] burstLen;
        logic [EVENT_WIDTH-1:0] density;
    } TestCase;

    logic clock;
    logic reset;
    PerfEvent events;
    WbRequest wbReq;
    WbResponse wbRsp;

    TestCase cases[$];
    int expected[PERF_NUM_COUNTERS];
    integer seed;
    int cycleCount;
    int cycleLimit;
    logic [`WB_DATA_WIDTH-1:0] data;

    PerfMonitorTop i_PerfMonitorTop (
        .clock(clock), .reset(reset), .events(events), .wbReq(wbReq), .wbRsp(wbRsp)
    );

    always #4 clock = ~clock;

    // The limit stays 0 until the case file has been read.
    always @(posedge clock) begin
        cycleCount++;
        if (cycleLimit != 0 && cycleCount > cycleLimit) begin
            failRun($sformatf("run did not finish within %0d cycles", cycleLimit));
        end
    end

    task automatic failRun(input string reason);
        $display("CHECKS FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expectedValue,
                              input string message);
        if (actual !== expectedValue) begin
            $display("mismatch at %0t: %s, read %h, expected %h",
                     $time, message, actual, expectedValue);
            failRun("a value read from the DUT was wrong");
        end
    endtask

    task automatic idleCycles(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            #1;
        end
    endtask

    // One Wishbone classic access. It starts and ends 1 ns after a rising edge.
    task automatic busAccess(input logic we, input logic [`WB_ADDR_WIDTH-1:0] adr,
                             input logic [`WB_DATA_WIDTH-1:0] datW,
                             output logic [`WB_DATA_WIDTH-1:0] datR);
        int waited;
        waited = 0;
        wbReq.cyc = 1'b1;
        wbReq.stb = 1'b1;
        wbReq.we = we;
        wbReq.adr = adr;
        wbReq.datW = datW;
        do begin
            idleCycles(1);
            waited++;
        end while (!wbRsp.ack && waited < 4);
        if (!wbRsp.ack) begin
            failRun($sformatf("no ack came for the access to address %0d", adr));
        end else begin
            datR = wbRsp.datR;
            wbReq = '0;
            idleCycles(1);
        end
    endtask

    task automatic writeReg(input logic [`WB_ADDR_WIDTH-1:0] adr,
                            input logic [`WB_DATA_WIDTH-1:0] value);
        logic [`WB_DATA_WIDTH-1:0] ignored;
        busAccess(1'b1, adr, value, ignored);
    endtask

    task automatic readReg(input logic [`WB_ADDR_WIDTH-1:0] adr,
                           output logic [`WB_DATA_WIDTH-1:0] value);
        busAccess(1'b0, adr, '0, value);
    endtask

    // Random events masked by the density. Only a counted burst updates the model.
    task automatic driveBurst(input int cycles, input logic [EVENT_WIDTH-1:0] density,
                              input bit counted);
        logic [EVENT_WIDTH-1:0] raw;
        repeat (cycles) begin
            raw = EVENT_WIDTH'($random(seed));
            events = PerfEvent'(raw & density);
            if (counted) begin
                for (int i = 0; i < `LOAD_ISSUE_WIDTH; i++) begin
                    expected[0] += int'(events.loadMiss[i]);
                end
                for (int i = 0; i < `STORE_ISSUE_WIDTH; i++) begin
                    expected[1] += int'(events.storeMiss[i]);
                end
                expected[2] += int'(events.icMiss);
                expected[3] += int'(events.branchPredMiss);
                expected[4] += int'(events.memDepPredMiss);
                expected[5] += int'(events.stallByScheduler);
                expected[6] += int'(events.stallByActiveList);
                expected[7] += int'(events.inRecovery);
            end
            idleCycles(1);
        end
        events = '0;
    endtask

    task automatic checkSnapshots(input string what);
        logic [`WB_DATA_WIDTH-1:0] value;
        for (int i = 0; i < PERF_NUM_COUNTERS; i++) begin
            readReg(`WB_ADDR_WIDTH'(int'(REG_SNAP_BASE) + i), value);
            checkValue(value, `WB_DATA_WIDTH'(expected[i] % (1 << `PERF_COUNTER_WIDTH)),
                       $sformatf("snapshot %0d %s", i, what));
        end
    endtask

    task automatic checkStatus(input logic busyBit, input logic doneBit,
                               input logic [15:0] count, input string what);
        logic [`WB_DATA_WIDTH-1:0] value;
        logic [`WB_DATA_WIDTH-1:0] want;
        readReg(REG_STATUS, value);
        want = '0;
        want[0] = busyBit;
        want[1] = doneBit;
        want[31:16] = count;
        checkValue(value, want, {"STATUS ", what});
    endtask

    task automatic loadCases();
        int fd;
        int mode;
        int window;
        int offset;
        int burstLen;
        logic [31:0] density;
        string line;
        TestCase tc;
        fd = $fopen("tb/perfCases.txt", "r");
        if (fd == 0) begin
            failRun("cannot open tb/perfCases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#" &&
                        $sscanf(line, "%d %d %d %d %h", mode, window, offset, burstLen,
                                density) == 5) begin
                    tc.oneShot = (mode != 0);
                    tc.window = 16'(window);
                    tc.offset = 16'(offset);
                    tc.burstLen = 16'(burstLen);
                    tc.density = density[EVENT_WIDTH-1:0];
                    cases.push_back(tc);
                    cycleLimit += window + 200;
                end
            end
            $fclose(fd);
            if (cases.size() == 0) begin
                failRun("tb/perfCases.txt holds no cases");
            end
        end
    endtask

    // The enabling write returns one counted cycle into the window.
    task automatic runOneShot(input TestCase tc);
        logic [`WB_DATA_WIDTH-1:0] value;
        if (tc.offset < 2 || tc.offset + tc.burstLen + 4 > tc.window) begin
            failRun("a one-shot case in tb/perfCases.txt does not fit inside its window");
        end else begin
            writeReg(REG_CTRL, 32'h3);
            idleCycles(tc.offset);
            driveBurst(tc.burstLen, tc.density, 1'b1);
            value = '0;
            while (!value[1]) begin
                readReg(REG_STATUS, value);
            end
            checkSnapshots("after the one-shot window");
            checkStatus(1'b0, 1'b1, 16'd1, "after the one-shot window");
            readReg(REG_CTRL, value);
            checkValue(value, 32'h3, "CTRL readback while held");
            driveBurst(tc.burstLen, tc.density, 1'b0);
            checkSnapshots("while held");
            checkStatus(1'b0, 1'b1, 16'd1, "while held");
        end
    endtask

    task automatic runContinuous(input TestCase tc);
        logic [`WB_DATA_WIDTH-1:0] value;
        writeReg(REG_CTRL, 32'h1);
        idleCycles(tc.offset);
        driveBurst(tc.burstLen, tc.density, 1'b0);
        value = '0;
        while (value[31:16] < CONT_WINDOWS) begin
            readReg(REG_STATUS, value);
            checkValue(32'(value[0]), 32'h1, "busy while windows run back to back");
        end
        writeReg(REG_CTRL, 32'h0);
        readReg(REG_STATUS, value);
        checkValue(32'(value[1:0]), 32'h0, "busy and done after stop");
        checkValue(32'(value[31:16] >= CONT_WINDOWS), 32'h1, "windowCount after stop");
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        events = '0;
        wbReq = '0;
        seed = 32'hb78f158f;
        cycleCount = 0;
        cycleLimit = 0;
        loadCases();
        idleCycles(16);
        reset = 1'b0;
        foreach (expected[i]) expected[i] = 0;
        checkSnapshots("after reset");
        checkStatus(1'b0, 1'b0, 16'd0, "after reset");
        writeReg(REG_WINDOW, 32'h5a3c);
        readReg(REG_WINDOW, data);
        checkValue(data, 32'h5a3c, "WINDOW readback");
        // Clear is write-only, so only oneShot reads back.
        writeReg(REG_CTRL, 32'h6);
        readReg(REG_CTRL, data);
        checkValue(data, 32'h2, "CTRL readback");
        readReg(`WB_ADDR_WIDTH'(3), data);
        checkValue(data, 32'h0, "unmapped address 3");
        foreach (cases[i]) begin
            writeReg(REG_CTRL, 32'h4);
            foreach (expected[j]) expected[j] = 0;
            checkSnapshots("after clear");
            checkStatus(1'b0, 1'b0, 16'd0, "after clear");
            writeReg(REG_WINDOW, 32'(cases[i].window));
            if (cases[i].oneShot) begin
                runOneShot(cases[i]);
            end else begin
                runContinuous(cases[i]);
            end
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== tb/PerfMonitor_assertions.sv ====
/* Bus and counter properties of PerfMonitorTop. They are ignored while reset is high. */
`timescale 1ns/1ps

module PerfMonitorAssertions (
    input logic clock,
    input logic reset,
    input PerfBusTypes::WbRequest wbReq,
    input PerfBusTypes::WbResponse wbRsp,
    input logic countEnable,
    input logic restart,
    input logic captureStrobe,
    input logic lastCycle,
    input PerfEventTypes::PerfCounterPath counts
);

    // A request seen while ack is low is answered on the next edge.
    ackFollowsRequest: assert property (@(posedge clock) disable iff (reset)
        (wbReq.cyc && wbReq.stb && !wbRsp.ack) |=> wbRsp.ack)
        else $error("ack did not follow a Wishbone request by one cycle");

    ackSingleCycle: assert property (@(posedge clock) disable iff (reset)
        wbRsp.ack |=> !wbRsp.ack)
        else $error("ack stayed high for two cycles");

    // Only a restart may change the counters outside a counting window.
    countsHoldWhenDisabled: assert property (@(posedge clock) disable iff (reset)
        (!countEnable && !restart) |=> $stable(counts))
        else $error("counters changed while counting was disabled");

    // A capture closes the window, so the bank starts the next one from zero.
    captureOnLastCycle: assert property (@(posedge clock) disable iff (reset)
        captureStrobe |-> lastCycle ##1 (counts == '0))
        else $error("a capture came outside the last cycle or did not restart the counters");

endmodule

bind PerfMonitorTop PerfMonitorAssertions i_PerfMonitorAssertions (
    .clock(clock), .reset(reset), .wbReq(wbReq), .wbRsp(wbRsp),
    .countEnable(countEnable), .restart(restart), .captureStrobe(captureStrobe),
    .lastCycle(lastCycle), .counts(counts)
);

// ==== src/PerfMonitorTop.sv ====
/* Performance monitor for the pipeline's miss and stall events, read over Wishbone.
   There are no interrupts and no overflow flags. */
`timescale 1ns/1ps
`include "perfMonitor_config.svh"

module PerfMonitorTop (
    input  logic clock,
    input  logic reset,
    input  PerfEventTypes::PerfEvent events,
    input  PerfBusTypes::WbRequest wbReq,
    output PerfBusTypes::WbResponse wbRsp
);
    import PerfEventTypes::*;

    logic startPulse;
    logic stopPulse;
    logic clearPulse;
    logic oneShot;
    logic [`WINDOW_WIDTH-1:0] windowLen;
    logic countEnable;
    logic restart;
    logic load;
    logic reload;
    logic captureStrobe;
    logic lastCycle;
    logic busy;
    logic done;
    // Running totals of the open window, kept visible for debug.
    PerfCounterPath counts;
    PerfCounterPath nextCounts;
    PerfCounterPath counterSnap;
    WindowStamp windowCount;
    WindowStamp stampSnap;

    PerfCounterBank i_PerfCounterBank (.*);

    WindowTimer i_WindowTimer (.*);

    PerfControlFsm i_PerfControlFsm (.*);

    PerfSnapshot #(.payloadT(PerfCounterPath)) i_CounterSnapshot (
        .clock(clock), .reset(reset), .clear(clearPulse), .captureStrobe(captureStrobe),
        .din(nextCounts), .dout(counterSnap)
    );

    PerfSnapshot #(.payloadT(WindowStamp)) i_StampSnapshot (
        .clock(clock), .reset(reset), .clear(clearPulse), .captureStrobe(captureStrobe),
        .din(windowCount), .dout(stampSnap)
    );

    PerfRegisterPort i_PerfRegisterPort (.*);

endmodule

// ==== src/PerfRegisterPort.sv ====
/* Zero-wait-state Wishbone classic slave. A new request is taken only when ack is low, so
   the master must drop stb after ack. Unmapped addresses read as 0. */
`timescale 1ns/1ps
`include "perfMonitor_config.svh"

module PerfRegisterPort (
    input  logic clock,
    input  logic reset,
    input  PerfBusTypes::WbRequest wbReq,
    output PerfBusTypes::WbResponse wbRsp,
    input  logic busy,
    input  logic done,
    input  PerfEventTypes::PerfCounterPath counterSnap,
    input  PerfEventTypes::WindowStamp stampSnap,
    output logic startPulse,
    output logic stopPulse,
    output logic clearPulse,
    output logic oneShot,
    output logic [`WINDOW_WIDTH-1:0] windowLen
);
    import PerfBusTypes::*;
    import PerfEventTypes::*;

    logic accept;
    logic ctrlWrite;
    logic enableReg;
    logic [`WB_ADDR_WIDTH-1:0] snapIndex;
    logic [`WB_DATA_WIDTH-1:0] readData;
    logic [PERF_NUM_COUNTERS-1:0][`PERF_COUNTER_WIDTH-1:0] snapArray;

    assign accept = wbReq.cyc && wbReq.stb && !wbRsp.ack;
    assign ctrlWrite = accept && wbReq.we && (wbReq.adr == REG_CTRL);

    // Pulses fire in the request cycle, so the FSM moves on the edge that raises ack.
    assign startPulse = ctrlWrite && wbReq.datW[CTRL_ENABLE_BIT];
    assign stopPulse = ctrlWrite && !wbReq.datW[CTRL_ENABLE_BIT];
    assign clearPulse = ctrlWrite && wbReq.datW[CTRL_CLEAR_BIT];

    // The first struct field lands in the top slice of the flat array.
    assign snapArray = counterSnap;
    assign snapIndex = wbReq.adr - REG_SNAP_BASE;

    always_comb begin
        readData = '0;
        case (wbReq.adr)
            REG_CTRL: readData = `WB_DATA_WIDTH'({oneShot, enableReg});
            REG_WINDOW: readData = `WB_DATA_WIDTH'(windowLen);
            REG_STATUS: begin
                readData[0] = busy;
                readData[1] = done;
                readData[STATUS_COUNT_LSB +: WINDOW_COUNT_WIDTH] = stampSnap.windowCount;
            end
            default: begin
                if (wbReq.adr >= REG_SNAP_BASE && int'(snapIndex) < PERF_NUM_COUNTERS) begin
                    readData = `WB_DATA_WIDTH'(snapArray[PERF_NUM_COUNTERS - 1 - int'(snapIndex)]);
                end
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            enableReg <= 1'b0;
            oneShot <= 1'b0;
            windowLen <= '0;
            wbRsp <= '0;
        end else begin
            wbRsp.ack <= accept;
            wbRsp.datR <= readData;
            if (ctrlWrite) begin
                enableReg <= wbReq.datW[CTRL_ENABLE_BIT];
                oneShot <= wbReq.datW[CTRL_ONESHOT_BIT];
            end
            if (accept && wbReq.we && wbReq.adr == REG_WINDOW) begin
                windowLen <= wbReq.datW[`WINDOW_WIDTH-1:0];
            end
        end
    end

endmodule

// ==== src/PerfSnapshot.sv ====
/* Clear wins over a capture on the same edge. */
`timescale 1ns/1ps

module PerfSnapshot #(
    parameter type payloadT = logic [31:0]
) (
    input  logic clock,
    input  logic reset,
    input  logic clear,
    input  logic captureStrobe,
    input  payloadT din,
    output payloadT dout
);

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            dout <= '0;
        end else if (captureStrobe) begin
            dout <= din;
        end
    end

endmodule

// ==== src/PerfControlFsm.sv ====
/* Each start begins a fresh window with zeroed counters. Clear takes priority over any
   other command in the same write. */
`timescale 1ns/1ps

module PerfControlFsm (
    input  logic clock,
    input  logic reset,
    input  logic startPulse,
    input  logic stopPulse,
    input  logic clearPulse,
    input  logic oneShot,
    input  logic lastCycle,
    output logic countEnable,
    output logic restart,
    output logic load,
    output logic reload,
    output logic captureStrobe,
    output logic busy,
    output logic done,
    output PerfEventTypes::WindowStamp windowCount
);
    import PerfEventTypes::*;

    typedef enum logic [1:0] {Idle, Counting, Held} FsmState;

    FsmState state;
    FsmState nextState;
    logic [WINDOW_COUNT_WIDTH-1:0] completedWindows;

    always_comb begin
        nextState = state;
        if (clearPulse) begin
            nextState = Idle;
        end else if (startPulse) begin
            nextState = Counting;
        end else if (stopPulse) begin
            nextState = Idle;
        end else if (captureStrobe && oneShot) begin
            nextState = Held;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    assign countEnable = (state == Counting);
    assign captureStrobe = countEnable && lastCycle;
    assign restart = captureStrobe || clearPulse || startPulse;
    assign load = startPulse && !clearPulse;
    assign reload = captureStrobe;
    assign busy = (state == Counting);
    assign done = (state == Held);

    // The output already includes the window closing this cycle, so the stamp snapshot
    // matches the counter snapshot taken on the same edge.
    always_comb begin
        windowCount = '0;
        windowCount.windowCount = completedWindows + WINDOW_COUNT_WIDTH'(captureStrobe);
    end

    always_ff @(posedge clock) begin
        if (reset || clearPulse) begin
            completedWindows <= '0;
        end else begin
            completedWindows <= windowCount.windowCount;
        end
    end

endmodule

// ==== src/WindowTimer.sv ====
/* Window length 0 behaves as 1. After a window ends without a reload the timer rests at zero
   with lastCycle high. */
`timescale 1ns/1ps
`include "perfMonitor_config.svh"

module WindowTimer (
    input  logic clock,
    input  logic reset,
    input  logic load,
    input  logic reload,
    input  logic [`WINDOW_WIDTH-1:0] windowLen,
    output logic lastCycle
);
    logic [`WINDOW_WIDTH-1:0] remaining;
    logic [`WINDOW_WIDTH-1:0] startValue;

    // Cycles left after the current one.
    assign startValue = (windowLen == '0) ? '0 : windowLen - 1'b1;

    always_ff @(posedge clock) begin
        if (reset) begin
            remaining <= '0;
        end else if (load || reload) begin
            remaining <= startValue;
        end else if (remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    assign lastCycle = (remaining == '0);

endmodule

// ==== src/PerfCounterBank.sv ====
/* One counter per event class, all wrapping at PERF_COUNTER_WIDTH. An event shows up in
   counts one cycle after it is presented. */
`timescale 1ns/1ps
`include "perfMonitor_config.svh"

module PerfCounterBank (
    input  logic clock,
    input  logic reset,
    input  PerfEventTypes::PerfEvent events,
    input  logic countEnable,
    input  logic restart,
    output PerfEventTypes::PerfCounterPath counts,
    output PerfEventTypes::PerfCounterPath nextCounts
);
    import PerfEventTypes::*;

    // Restart only affects the register, so nextCounts still carries this cycle's events.
    always_ff @(posedge clock) begin
        if (reset || restart) begin
            counts <= '0;
        end else begin
            counts <= nextCounts;
        end
    end

    always_comb begin
        nextCounts = counts;
        if (countEnable) begin
            // Every lane that missed adds one.
            for (int i = 0; i < `LOAD_ISSUE_WIDTH; i++) begin
                nextCounts.numLoadMiss += `PERF_COUNTER_WIDTH'(events.loadMiss[i]);
            end
            for (int i = 0; i < `STORE_ISSUE_WIDTH; i++) begin
                nextCounts.numStoreMiss += `PERF_COUNTER_WIDTH'(events.storeMiss[i]);
            end
            nextCounts.numIcMiss += `PERF_COUNTER_WIDTH'(events.icMiss);
            nextCounts.numBranchPredMiss += `PERF_COUNTER_WIDTH'(events.branchPredMiss);
            nextCounts.numMemDepPredMiss += `PERF_COUNTER_WIDTH'(events.memDepPredMiss);
            nextCounts.stallByScheduler += `PERF_COUNTER_WIDTH'(events.stallByScheduler);
            nextCounts.stallByActiveList += `PERF_COUNTER_WIDTH'(events.stallByActiveList);
            // Recovery cycles are counted as stalls.
            nextCounts.stallByRecovery += `PERF_COUNTER_WIDTH'(events.inRecovery);
        end
    end

endmodule

// ==== src/PerfBusTypes.sv ====
/* Wishbone classic types and the register map. There are no byte selects, so every
   access is a full word. */
`include "perfMonitor_config.svh"

package PerfBusTypes;

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [`WB_ADDR_WIDTH-1:0] adr;
        logic [`WB_DATA_WIDTH-1:0] datW;
    } WbRequest;

    typedef struct packed {
        logic ack;
        logic [`WB_DATA_WIDTH-1:0] datR;
    } WbResponse;

    // Word addresses. Snapshot counter i sits at REG_SNAP_BASE + i.
    localparam logic [`WB_ADDR_WIDTH-1:0] REG_CTRL      = 4'd0;
    localparam logic [`WB_ADDR_WIDTH-1:0] REG_WINDOW    = 4'd1;
    localparam logic [`WB_ADDR_WIDTH-1:0] REG_STATUS    = 4'd2;
    localparam logic [`WB_ADDR_WIDTH-1:0] REG_SNAP_BASE = 4'd8;

    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_ONESHOT_BIT = 1;
    localparam int CTRL_CLEAR_BIT = 2;
    localparam int STATUS_COUNT_LSB = 16;

endpackage

// ==== src/PerfEventTypes.sv ====
/* Event and counter types. The field order of PerfCounterPath fixes the snapshot read map,
   with numLoadMiss at the first snapshot address. */
`include "perfMonitor_config.svh"

package PerfEventTypes;

    localparam int PERF_NUM_COUNTERS = 8;
    localparam int WINDOW_COUNT_WIDTH = 16;

    // Per-cycle event bits presented by the pipeline.
    typedef struct packed {
        logic [`LOAD_ISSUE_WIDTH-1:0]  loadMiss;
        logic [`STORE_ISSUE_WIDTH-1:0] storeMiss;
        logic icMiss;
        logic branchPredMiss;
        logic memDepPredMiss;
        logic stallByScheduler;
        logic stallByActiveList;
        logic inRecovery;
    } PerfEvent;

    typedef struct packed {
        logic [`PERF_COUNTER_WIDTH-1:0] numLoadMiss;
        logic [`PERF_COUNTER_WIDTH-1:0] numStoreMiss;
        logic [`PERF_COUNTER_WIDTH-1:0] numIcMiss;
        logic [`PERF_COUNTER_WIDTH-1:0] numBranchPredMiss;
        logic [`PERF_COUNTER_WIDTH-1:0] numMemDepPredMiss;
        logic [`PERF_COUNTER_WIDTH-1:0] stallByScheduler;
        logic [`PERF_COUNTER_WIDTH-1:0] stallByActiveList;
        logic [`PERF_COUNTER_WIDTH-1:0] stallByRecovery;
    } PerfCounterPath;

    // Number of windows completed since the last clear.
    typedef struct packed {
        logic [WINDOW_COUNT_WIDTH-1:0] windowCount;
    } WindowStamp;

endpackage

// ==== src/perfMonitor_config.svh ====
/* Build-time sizes for the performance monitor. The bus is word addressed, so WB_ADDR_WIDTH
   covers the whole register map. */
`ifndef PERF_MONITOR_CONFIG_SVH
`define PERF_MONITOR_CONFIG_SVH

// Issue lanes that can report a miss in the same cycle.
`define LOAD_ISSUE_WIDTH 2
`define STORE_ISSUE_WIDTH 1

// Counters wrap silently at this width.
`define PERF_COUNTER_WIDTH 16

`define WB_ADDR_WIDTH 4
`define WB_DATA_WIDTH 32
`define WINDOW_WIDTH 16

`endif
